//--- hw/riscv_dma_pkg.sv
// Flit width, header field layout, packet type codes, flit union and AHB-Lite constants
`default_nettype none

package riscv_dma_pkg;

  //////////////////////////////////////////////////////////////////////
  // Flit and header layout
  //////////////////////////////////////////////////////////////////////

  // Flit width, also the AHB address and data width
  localparam int flit_width = 32;

  // Widest packet id, table index takes the low bits
  localparam int id_width = 4;

  // Header field widths
  localparam int dest_width     = 5;
  localparam int ptype_width    = 3;
  localparam int reserved_width = flit_width - dest_width - ptype_width - id_width - 1;

  // Packet types seen on the response path, all other codes are unknown
  localparam logic [ptype_width-1:0] pkt_type_l2r_resp = 3'd2;
  localparam logic [ptype_width-1:0] pkt_type_r2l_resp = 3'd3;

  // Header view, MSB first
  typedef struct packed {
    logic [dest_width-1:0]     dest;      // 31..27
    logic [ptype_width-1:0]    ptype;     // 26..24
    logic [id_width-1:0]       id;        // 23..20
    logic                      res_last;  // 19, final packet of the response
    logic [reserved_width-1:0] reserved;
  } flit_hdr_t;

  // One flit word, read as header or as plain content
  typedef union packed {
    flit_hdr_t             hdr;
    logic [flit_width-1:0] data;
  } flit_t;

  //////////////////////////////////////////////////////////////////////
  // AHB-Lite encodings
  //////////////////////////////////////////////////////////////////////

  // Transfer types
  localparam logic [1:0] htrans_idle   = 2'b00;
  localparam logic [1:0] htrans_nonseq = 2'b10;
  localparam logic [1:0] htrans_seq    = 2'b11;

  // Undefined-length incrementing burst
  localparam logic [2:0] hburst_incr = 3'b001;

  // 32-bit transfers only
  localparam logic [2:0] hsize_word = 3'b010;

  // Address step per beat
  localparam int word_bytes = 4;

endpackage

`default_nettype wire

//--- hw/riscv_dma_buffer.sv
// Flit FIFO with a last bit per entry and valid/ready handshake on both sides
`timescale 1ns/1ps
`default_nettype none

module riscv_dma_buffer #(
  parameter int depth = 16
) (
  input  logic                 clk,
  input  logic                 rst,

  // Write side, from the NoC
  input  riscv_dma_pkg::flit_t in_flit,
  input  logic                 in_last,
  input  logic                 in_valid,
  output logic                 in_ready,

  // Read side, to the response handler
  output riscv_dma_pkg::flit_t out_flit,
  output logic                 out_last,
  output logic                 out_valid,
  input  logic                 out_ready
);

  localparam int ptr_width = $clog2(depth);

  // Storage
  riscv_dma_pkg::flit_t flit_mem [depth];
  logic                 last_mem [depth];

  // Pointers wrap on their own, depth is a power of two
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [ptr_width:0]   count;

  logic push;
  logic pop;

  //////////////////////////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////////////////////////

  // Full only blocks the writer
  assign in_ready  = (count != (ptr_width + 1)'(depth));
  assign out_valid = (count != '0);

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // Head entry straight from the array
  assign out_flit = flit_mem[rd_ptr];
  assign out_last = last_mem[rd_ptr];

  //////////////////////////////////////////////////////////////////////
  // Storage write
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      flit_mem[wr_ptr] <= in_flit;
      last_mem[wr_ptr] <= in_last;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Pointers and fill level
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the level unchanged
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Fill level stays within the array
  assert property (@(posedge clk) disable iff (rst)
    count <= (ptr_width + 1)'(depth))
    else $error("flit buffer over depth");

endmodule

`default_nettype wire

//--- hw/riscv_dma_initiator_response.sv
// Response packet decoder and AHB-Lite incrementing burst writer for read data
`timescale 1ns/1ps
`default_nettype none

module riscv_dma_initiator_response #(
  parameter int table_entries = 4
) (
  input  logic                             clk,
  input  logic                             rst,

  // Flits from the buffer
  input  riscv_dma_pkg::flit_t             buf_flit,
  input  logic                             buf_last,
  input  logic                             buf_valid,
  output logic                             buf_ready,

  // AHB-Lite master
  output logic [31:0]                      haddr,
  output logic [31:0]                      hwdata,
  output logic                             hsel,
  output logic                             hwrite,
  output logic                             hmastlock,
  output logic [1:0]                       htrans,
  output logic [2:0]                       hsize,
  output logic [2:0]                       hburst,
  output logic [3:0]                       hprot,
  input  logic                             hready,
  input  logic                             hresp,

  // Done strobe to the table
  output logic                             done_set_en,
  output logic [$clog2(table_entries)-1:0] done_set_pos
);

  localparam int pos_width = $clog2(table_entries);

  // Data access, privileged
  localparam logic [3:0] hprot_data = 4'b0011;

  typedef enum logic [2:0] {
    st_idle,
    st_get_size,
    st_get_addr,
    st_write,
    st_discard
  } state_t;

  state_t state;

  // Control
  logic seq_ok;     // Next beat continues the burst
  logic last_pend;  // Data phase of the final beat in flight

  // Payload
  logic [31:0]          addr_q;
  logic [31:0]          wdata_q;
  logic [31:0]          beat_cnt;
  logic                 res_last_q;

  logic beat_req;
  logic beat_acc;
  logic last_done;

  //////////////////////////////////////////////////////////////////////
  // Bus side
  //////////////////////////////////////////////////////////////////////

  // A beat is offered whenever a data flit waits and the packet is open
  assign beat_req  = (state == st_write) && buf_valid && !last_pend;
  assign beat_acc  = beat_req && hready;
  assign last_done = (state == st_write) && last_pend && hready;

  // Header flits are taken at once, data only as the address phase completes
  always_comb begin
    case (state)
      st_write: buf_ready = hready && !last_pend;
      default:  buf_ready = 1'b1;
    endcase
  end

  assign hsel      = (state == st_write);
  assign hwrite    = (state == st_write);
  assign hmastlock = 1'b0;
  assign htrans    = !beat_req ? riscv_dma_pkg::htrans_idle :
                     seq_ok    ? riscv_dma_pkg::htrans_seq  :
                                 riscv_dma_pkg::htrans_nonseq;
  assign hsize     = riscv_dma_pkg::hsize_word;
  assign hburst    = riscv_dma_pkg::hburst_incr;
  assign hprot     = hprot_data;
  assign haddr     = addr_q;
  assign hwdata    = wdata_q;

  //////////////////////////////////////////////////////////////////////
  // Packet FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= st_idle;
      seq_ok      <= 1'b0;
      last_pend   <= 1'b0;
      done_set_en <= 1'b0;
    end else begin
      done_set_en <= 1'b0;
      case (state)
        st_idle: begin
          if (buf_valid) begin
            case (buf_flit.hdr.ptype)
              riscv_dma_pkg::pkt_type_l2r_resp: begin
                done_set_en <= 1'b1;
                // A longer ack than expected is drained
                if (!buf_last) begin
                  state <= st_discard;
                end
              end
              riscv_dma_pkg::pkt_type_r2l_resp: begin
                state <= st_get_size;
              end
              default: begin
                if (!buf_last) begin
                  state <= st_discard;
                end
              end
            endcase
          end
        end
        st_get_size: begin
          if (buf_valid) begin
            state <= st_get_addr;
          end
        end
        st_get_addr: begin
          if (buf_valid) begin
            seq_ok <= 1'b0;
            state  <= st_write;
          end
        end
        st_write: begin
          // Burst stays sequential only while beats follow without a gap
          if (hready) begin
            seq_ok <= beat_req;
          end
          if (beat_acc && buf_last) begin
            last_pend <= 1'b1;
          end
          if (last_done) begin
            last_pend   <= 1'b0;
            done_set_en <= res_last_q;
            state       <= st_idle;
          end
        end
        st_discard: begin
          if (buf_valid && buf_last) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Header fields, address, write data and beat count
  always_ff @(posedge clk) begin
    if (state == st_idle && buf_valid) begin
      res_last_q   <= buf_flit.hdr.res_last;
      done_set_pos <= buf_flit.hdr.id[pos_width-1:0];
    end
    if (state == st_get_size && buf_valid) begin
      beat_cnt <= buf_flit.data;
    end
    if (state == st_get_addr && buf_valid) begin
      addr_q <= buf_flit.data;
    end
    // Flit moves into the data phase as its address is taken
    if (beat_acc) begin
      wdata_q  <= buf_flit.data;
      addr_q   <= addr_q + 32'(riscv_dma_pkg::word_bytes);
      beat_cnt <= beat_cnt - 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // No error recovery on this path
  assert property (@(posedge clk) disable iff (rst) !hresp)
    else $error("AHB error response");

  // Size flit matches the data flits up to the last marker
  assert property (@(posedge clk) disable iff (rst) last_done |-> beat_cnt == '0)
    else $error("beat count mismatch at end of packet");

  assert property (@(posedge clk) disable iff (rst)
    !hsel |-> htrans == riscv_dma_pkg::htrans_idle)
    else $error("transfer without select");

endmodule

`default_nettype wire

//--- hw/riscv_dma_done_table.sv
// Done flags of the transfer slots, set by the response handler, cleared by the controller
`timescale 1ns/1ps
`default_nettype none

module riscv_dma_done_table #(
  parameter int table_entries = 4
) (
  input  logic                             clk,
  input  logic                             rst,

  // Set strobe from the response handler
  input  logic                             done_set_en,
  input  logic [$clog2(table_entries)-1:0] done_set_pos,

  // Clear strobe from the DMA controller
  input  logic                             done_clr_en,
  input  logic [$clog2(table_entries)-1:0] done_clr_pos,

  // One flag per slot
  output logic [table_entries-1:0]         done_vec
);

  logic [table_entries-1:0] set_mask;
  logic [table_entries-1:0] clr_mask;

  //////////////////////////////////////////////////////////////////////
  // Strobe decode
  //////////////////////////////////////////////////////////////////////

  // One-hot masks from the slot indices
  always_comb begin
    set_mask = '0;
    clr_mask = '0;
    if (done_set_en) begin
      set_mask[done_set_pos] = 1'b1;
    end
    if (done_clr_en) begin
      clr_mask[done_clr_pos] = 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Flags
  //////////////////////////////////////////////////////////////////////

  // Set is applied after the clear, so it wins on the same slot
  always_ff @(posedge clk) begin
    if (rst) begin
      done_vec <= '0;
    end else begin
      done_vec <= (done_vec & ~clr_mask) | set_mask;
    end
  end

  // Controller must clear a slot before it is reused
  assert property (@(posedge clk) disable iff (rst)
    done_set_en |-> !done_vec[done_set_pos])
    else $error("done set on a slot already done");

endmodule

`default_nettype wire

//--- hw/riscv_dma_initiator_rx.sv
// Response path top level with flit buffer, response handler and done table
`timescale 1ns/1ps
`default_nettype none

module riscv_dma_initiator_rx #(
  parameter int table_entries = 4,
  parameter int buffer_depth  = 16
) (
  input  logic                                   clk,
  input  logic                                   rst,

  // NoC response input
  input  logic [riscv_dma_pkg::flit_width-1:0]   noc_in_flit,
  input  logic                                   noc_in_last,
  input  logic                                   noc_in_valid,
  output logic                                   noc_in_ready,

  // AHB-Lite master
  output logic [31:0]                            haddr,
  output logic [31:0]                            hwdata,
  output logic                                   hsel,
  output logic                                   hwrite,
  output logic                                   hmastlock,
  output logic [1:0]                             htrans,
  output logic [2:0]                             hsize,
  output logic [2:0]                             hburst,
  output logic [3:0]                             hprot,
  input  logic                                   hready,
  input  logic                                   hresp,

  // Done table access from the controller
  input  logic                                   done_clr_en,
  input  logic [$clog2(table_entries)-1:0]       done_clr_pos,
  output logic [table_entries-1:0]               done_vec
);

  // Buffer to handler
  riscv_dma_pkg::flit_t buf_flit;
  logic                 buf_last;
  logic                 buf_valid;
  logic                 buf_ready;

  // Handler to table
  logic                             done_set_en;
  logic [$clog2(table_entries)-1:0] done_set_pos;

  riscv_dma_buffer #(
    .depth (buffer_depth)
  ) buffer_i (
    .clk       (clk),
    .rst       (rst),
    .in_flit   (noc_in_flit),
    .in_last   (noc_in_last),
    .in_valid  (noc_in_valid),
    .in_ready  (noc_in_ready),
    .out_flit  (buf_flit),
    .out_last  (buf_last),
    .out_valid (buf_valid),
    .out_ready (buf_ready)
  );

  riscv_dma_initiator_response #(
    .table_entries (table_entries)
  ) response_i (
    .clk          (clk),
    .rst          (rst),
    .buf_flit     (buf_flit),
    .buf_last     (buf_last),
    .buf_valid    (buf_valid),
    .buf_ready    (buf_ready),
    .haddr        (haddr),
    .hwdata       (hwdata),
    .hsel         (hsel),
    .hwrite       (hwrite),
    .hmastlock    (hmastlock),
    .htrans       (htrans),
    .hsize        (hsize),
    .hburst       (hburst),
    .hprot        (hprot),
    .hready       (hready),
    .hresp        (hresp),
    .done_set_en  (done_set_en),
    .done_set_pos (done_set_pos)
  );

  riscv_dma_done_table #(
    .table_entries (table_entries)
  ) table_i (
    .clk          (clk),
    .rst          (rst),
    .done_set_en  (done_set_en),
    .done_set_pos (done_set_pos),
    .done_clr_en  (done_clr_en),
    .done_clr_pos (done_clr_pos),
    .done_vec     (done_vec)
  );

endmodule

`default_nettype wire

//--- verification/riscv_dma_rx_tests.svh
// Packet senders, wait helpers and the directed tests of the response path

  // Header through the union's header view
  function automatic logic [31:0] make_header(input logic [2:0] ptype, input int id,
                                              input logic res_last);
    riscv_dma_pkg::flit_t hdr;
    hdr.data         = '0;
    hdr.hdr.dest     = 5'd3;
    hdr.hdr.ptype    = ptype;
    hdr.hdr.id       = 4'(id);
    hdr.hdr.res_last = res_last;
    return hdr.data;
  endfunction

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send_flit(input logic [31:0] data, input logic last);
    noc_in_flit  = data;
    noc_in_last  = last;
    noc_in_valid = 1'b1;
    // Ready only moves on rising edges
    while (!noc_in_ready) begin
      ready_dropped = 1'b1;
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  task automatic send_ack(input int id);
    send_flit(make_header(riscv_dma_pkg::pkt_type_l2r_resp, id, 1'b1), 1'b1);
    noc_in_valid = 1'b0;
    noc_in_last  = 1'b0;
  endtask

  // Header, size, address and random data words, back to back
  task automatic send_read_response(input int id, input logic res_last,
                                    input logic [31:0] addr, input int nwords);
    logic [31:0] word;
    send_flit(make_header(riscv_dma_pkg::pkt_type_r2l_resp, id, res_last), 1'b0);
    send_flit(32'(nwords), 1'b0);
    send_flit(addr, 1'b0);
    for (int i = 0; i < nwords; i++) begin
      word = $random(seed);
      exp_mem[addr[9:2] + 8'(i)] = word;
      send_flit(word, i == nwords - 1);
    end
    noc_in_valid = 1'b0;
    noc_in_last  = 1'b0;
  endtask

  task automatic wait_flag(input int slot, input int limit);
    int n;
    n = 0;
    while (!done_vec[slot]) begin
      if (n == limit) begin
        $display("Done flag %0d did not rise within %0d cycles", slot, limit);
        stop_run();
      end
      n = n + 1;
      @(negedge clk);
    end
  endtask

  task automatic wait_beats(input int target, input int limit);
    int n;
    n = 0;
    while (beat_count < target) begin
      if (n == limit) begin
        $display("Only %0d of %0d AHB beats completed", beat_count, target);
        stop_run();
      end
      n = n + 1;
      @(negedge clk);
    end
  endtask

  task automatic clear_flag(input int slot);
    done_clr_en  = 1'b1;
    done_clr_pos = 2'(slot);
    @(negedge clk);
    done_clr_en  = 1'b0;
    check_equal(32'(done_vec[slot]), 32'd0, "done flag after clear");
  endtask

  task automatic check_memory;
    for (int i = 0; i < mem_words; i++) begin
      check_equal(mem[i], exp_mem[i], $sformatf("memory word %0d", i));
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////

  task automatic test_reset_state;
    check_equal(32'(noc_in_ready), 32'd1, "NoC ready after reset");
    check_equal(32'(hsel), 32'd0, "hsel after reset");
    check_equal(32'(htrans), 32'(riscv_dma_pkg::htrans_idle), "htrans after reset");
    check_equal(32'(hwrite), 32'd0, "hwrite after reset");
    check_equal(32'(hmastlock), 32'd0, "hmastlock after reset");
    check_equal(32'(done_vec), 32'd0, "done flags after reset");
  endtask

  // One-flit ack marks its slot and never touches the bus
  task automatic test_ack;
    int beats_before;
    beats_before = nonseq_count + seq_count;
    send_ack(2);
    wait_flag(2, 6);
    check_equal(32'(done_vec), 32'b0100, "done flags after ack");
    check_equal(32'(nonseq_count + seq_count), 32'(beats_before), "AHB beats during ack");
    clear_flag(2);
  endtask

  task automatic test_read_response;
    int nonseq_before;
    int seq_before;
    nonseq_before = nonseq_count;
    seq_before    = seq_count;
    wait_max      = 0;
    send_read_response(1, 1'b1, 32'h0000_0040, 8);
    wait_flag(1, 40);
    check_memory();
    check_equal(32'(nonseq_count - nonseq_before), 32'd1, "NONSEQ beats in burst");
    check_equal(32'(seq_count - seq_before), 32'd7, "SEQ beats in burst");
    check_equal(32'(done_vec), 32'b0010, "done flags after read response");
    clear_flag(1);
  endtask

  // First packet leaves the slot open, second one closes it
  task automatic test_multi_packet;
    int beats_before;
    wait_max     = 2;
    beats_before = beat_count;
    send_read_response(3, 1'b0, 32'h0000_0100, 5);
    wait_beats(beats_before + 5, 60);
    repeat (3) @(negedge clk);
    check_equal(32'(done_vec), 32'd0, "done flags after first packet");
    send_read_response(3, 1'b1, 32'h0000_0200, 6);
    wait_flag(3, 60);
    check_memory();
    check_equal(32'(done_vec), 32'b1000, "done flags after second packet");
    clear_flag(3);
  endtask

  // Long wait states fill the buffer while flits keep coming
  task automatic test_back_pressure;
    wait_max      = 5;
    ready_dropped = 1'b0;
    send_read_response(0, 1'b1, 32'h0000_0300, 40);
    check_equal(32'(ready_dropped), 32'd1, "NoC ready dropped under back-pressure");
    wait_flag(0, 300);
    check_memory();
    check_equal(32'(done_vec), 32'b0001, "done flags after back-pressure");
    clear_flag(0);
    wait_max = 0;
  endtask

  task automatic test_unknown_type;
    int beats_before;
    beats_before = nonseq_count + seq_count;
    // Type 5 is not a response, body looks like a read response
    send_flit(make_header(3'd5, 1, 1'b1), 1'b0);
    send_flit(32'h0000_0004, 1'b0);
    send_flit(32'h0000_0080, 1'b0);
    send_flit(32'hdead_beef, 1'b1);
    // Ack on another slot, so a flag raised by the discarded header shows up
    send_ack(2);
    wait_flag(2, 20);
    check_equal(32'(done_vec), 32'b0100, "done flags after discard and ack");
    check_equal(32'(nonseq_count + seq_count), 32'(beats_before), "AHB beats on discard");
    check_memory();
    clear_flag(2);
  endtask

//--- verification/riscv_dma_initiator_rx_tb.sv
// Testbench top with clock, reset, DUT, AHB-Lite memory model, checker, watchdog and sequence
`timescale 1ns/1ps
`default_nettype none

module riscv_dma_initiator_rx_tb;

  localparam int table_entries   = 4;
  localparam int mem_words       = 256;
  localparam int num_tests       = 6;
  localparam int cycles_per_test = 200;

  logic clk;
  logic rst;

  // NoC side
  logic [31:0] noc_in_flit;
  logic        noc_in_last;
  logic        noc_in_valid;
  logic        noc_in_ready;

  // AHB-Lite side
  logic [31:0] haddr;
  logic [31:0] hwdata;
  logic        hsel;
  logic        hwrite;
  logic        hmastlock;
  logic [1:0]  htrans;
  logic [2:0]  hsize;
  logic [2:0]  hburst;
  logic [3:0]  hprot;
  logic        hready = 1'b1;
  logic        hresp;

  // Done table
  logic                             done_clr_en;
  logic [$clog2(table_entries)-1:0] done_clr_pos;
  logic [table_entries-1:0]         done_vec;

  // Stimulus seed, shared by data words and wait states
  integer seed = 32'h7cd8_8af9;

  // Memory model state
  logic [31:0] mem     [mem_words];
  logic [31:0] exp_mem [mem_words];
  logic        dphase_open   = 1'b0;
  logic [31:0] dphase_addr   = '0;
  logic [31:0] prev_addr     = '0;
  logic        ready_dropped = 1'b0;
  int          wait_left     = 0;
  int          wait_max      = 0;
  int          beat_count    = 0;
  int          nonseq_count  = 0;
  int          seq_count     = 0;

  initial begin
    clk = 1'b0;
    // 100 ns period
    forever #50 clk = ~clk;
  end

  riscv_dma_initiator_rx #(
    .table_entries (table_entries)
  ) dut_i (
    .clk          (clk),
    .rst          (rst),
    .noc_in_flit  (noc_in_flit),
    .noc_in_last  (noc_in_last),
    .noc_in_valid (noc_in_valid),
    .noc_in_ready (noc_in_ready),
    .haddr        (haddr),
    .hwdata       (hwdata),
    .hsel         (hsel),
    .hwrite       (hwrite),
    .hmastlock    (hmastlock),
    .htrans       (htrans),
    .hsize        (hsize),
    .hburst       (hburst),
    .hprot        (hprot),
    .hready       (hready),
    .hresp        (hresp),
    .done_clr_en  (done_clr_en),
    .done_clr_pos (done_clr_pos),
    .done_vec     (done_vec)
  );

  ////////////////////////////////////////////////////////////////////
  // Checking and run control
  ////////////////////////////////////////////////////////////////////

  task automatic stop_run;
    $display("test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("Error at %0t: %s, got %h, expected %h", $time, what, actual, expected);
      stop_run();
    end
  endtask

  // Pattern over the whole word index
  function automatic logic [31:0] fill_word(input int idx);
    return 32'hc3a5_0000 ^ (32'(idx) * 32'h0001_0101);
  endfunction

  ////////////////////////////////////////////////////////////////////
  // AHB-Lite memory model
  ////////////////////////////////////////////////////////////////////

  // Works on falling edges, everything it sees is settled until the next rise
  always @(negedge clk) begin
    if (dphase_open && wait_left > 0) begin
      // Wait state, data phase and next address phase both stall
      hready    = 1'b0;
      wait_left = wait_left - 1;
    end else begin
      hready = 1'b1;
      // Open data phase completes on the coming edge
      if (dphase_open) begin
        mem[dphase_addr[9:2]] = hwdata;
        beat_count = beat_count + 1;
      end
      dphase_open = 1'b0;
      if (hsel && htrans[1]) begin
        check_equal(32'(hwrite), 32'd1, "write strobe on a beat");
        check_equal(32'(hsize), 32'(riscv_dma_pkg::hsize_word), "transfer size");
        check_equal(32'(hburst), 32'(riscv_dma_pkg::hburst_incr), "burst type");
        check_equal(32'(hmastlock), 32'd0, "locked transfer on a beat");
        check_equal(32'(hprot[0]), 32'd1, "data access in hprot");
        if (htrans == riscv_dma_pkg::htrans_nonseq) begin
          nonseq_count = nonseq_count + 1;
        end else begin
          seq_count = seq_count + 1;
          check_equal(haddr, prev_addr + 32'd4, "sequential beat address");
        end
        prev_addr   = haddr;
        dphase_addr = haddr;
        dphase_open = 1'b1;
        // wait states for this beat's data phase
        wait_left = (wait_max == 0) ? 0 : int'($unsigned($random(seed)) % (wait_max + 1));
      end
    end
  end

  // Whole run bounded by the number of tests
  initial begin
    repeat (num_tests * cycles_per_test) @(posedge clk);
    $display("Watchdog expired, the run timed out after %0d cycles",
             num_tests * cycles_per_test);
    stop_run();
  end

  ////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    rst          = 1'b1;
    noc_in_flit  = '0;
    noc_in_last  = 1'b0;
    noc_in_valid = 1'b0;
    hresp        = 1'b0;
    done_clr_en  = 1'b0;
    done_clr_pos = '0;
    for (int i = 0; i < mem_words; i++) begin
      mem[i]     = fill_word(i);
      exp_mem[i] = fill_word(i);
    end
    // Reset over three rising edges
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_reset_state();
    test_ack();
    test_read_response();
    test_multi_packet();
    test_back_pressure();
    test_unknown_type();
    $display("test passed");
    $finish;
  end

  `include "riscv_dma_rx_tests.svh"

endmodule

`default_nettype wire

//--- sim.f
+incdir+verification
hw/riscv_dma_pkg.sv
hw/riscv_dma_buffer.sv
hw/riscv_dma_initiator_response.sv
hw/riscv_dma_done_table.sv
hw/riscv_dma_initiator_rx.sv
verification/riscv_dma_initiator_rx_tb.sv

//--- Makefile
# Verilator flow for the DMA response path

VERILATOR ?= verilator
TOP       ?= riscv_dma_initiator_rx_tb
RTL_TOP   ?= riscv_dma_initiator_rx
SEED      ?= 1
BUILD_DIR ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --assert --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# Exit status of the simulation binary is the test result
run: build
	./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)
